// File: filelist.f
+incdir+source
source/iq_pkg.sv
source/iq_idx_counter.sv
source/iq_predecoder.sv
source/issue_queue_fifo.sv
source/issue_queue.sv
tb/tb_clkgen.sv
tb/issue_queue_chk.sv
tb/tb_issue_queue.sv

// File: run_sim.sh
#!/bin/sh
# Builds the issue queue testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f filelist.f \
    --top-module tb_issue_queue > build.log 2>&1 \
    && ./obj_dir/Vtb_issue_queue > sim.log 2>&1 \
    || echo "Build or run stopped early, see build.log and sim.log"
grep -qsx "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb/tb_issue_queue.sv
/* Issue queue testbench
   Directed tests checked against a reference queue and a predecoder table model */

`default_nettype none

`include "iq_defs.svh"

module tb_issue_queue
    import iq_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Outputs are sampled this long after the falling edge
    localparam int SETTLE  = 20;
    localparam int TIMEOUT = 50;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         fetch_valid;
    fetch_instr_t fetch_instr;
    logic         fetch_ready;
    logic         issue_ready;
    logic         issue_valid;
    iq_entry_t    issue_entry;

    // Expected contents with the oldest entry first
    iq_entry_t exp_q[$];

    // Outputs as sampled in the most recent cycle
    logic      seen_ready;
    logic      seen_valid;
    iq_entry_t seen_entry;

    logic [31:0] lfsr_q;
    int          value_errors;
    int          other_errors;
    int          assert_errors;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    issue_queue dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .fetch_valid_i (fetch_valid),
        .fetch_instr_i (fetch_instr),
        .fetch_ready_o (fetch_ready),
        .issue_ready_i (issue_ready),
        .issue_valid_o (issue_valid),
        .issue_entry_o (issue_entry)
    );

    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return val;
    endfunction

    function automatic fetch_instr_t random_fetch();
        fetch_instr_t fi;
        fi.pc     = next_bits(32);
        fi.instr  = next_bits(32);
        // Roughly one fetch in sixteen carries a fault
        fi.except = (next_bits(4) == 32'd0);
        return fi;
    endfunction

    // Unit table keyed on opcode bits 6:2
    function automatic iq_entry_t model_entry(input fetch_instr_t fi);
        iq_entry_t e;
        iq_unit_t  u;
        logic      known;
        known = 1'b1;
        u     = `IQ_UNIT_SYS;
        case (fi.instr[6:2])
            5'b01100, 5'b00100, 5'b01101, 5'b00101: u = `IQ_UNIT_ALU;
            5'b11000, 5'b11011, 5'b11001: u = `IQ_UNIT_BRANCH;
            5'b00000, 5'b01000: u = `IQ_UNIT_LSU;
            5'b11100, 5'b00011: u = `IQ_UNIT_SYS;
            default: known = 1'b0;
        endcase
        e.valid   = 1'b1;
        e.pc      = fi.pc;
        e.instr   = fi.instr;
        e.illegal = !known || (fi.instr[1:0] != 2'b11) || fi.except;
        e.unit    = e.illegal ? `IQ_UNIT_SYS : u;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [67:0] expected,
                               input logic [67:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // One clock cycle that drives on the falling edge, checks and then advances the model
    task automatic run_cycle(input logic valid, input fetch_instr_t fi, input logic ready,
                             input logic flush_req, output logic pushed, output logic popped);
        logic exp_ready;
        logic exp_valid;
        @(negedge clk);
        fetch_valid = valid;
        fetch_instr = fi;
        issue_ready = ready;
        flush       = flush_req;
        #SETTLE;
        exp_valid = (exp_q.size() != 0);
        exp_ready = !flush_req && ((exp_q.size() < `IQ_DEPTH) || (exp_valid && ready));
        seen_ready = fetch_ready;
        seen_valid = issue_valid;
        seen_entry = issue_entry;
        check_value("fetch_ready_o", 68'(exp_ready), 68'(seen_ready));
        check_value("issue_valid_o", 68'(exp_valid), 68'(seen_valid));
        if (exp_valid) begin
            check_value("issue_entry_o", 68'(exp_q[0]), 68'(seen_entry));
        end
        pushed = valid && exp_ready;
        popped = exp_valid && ready && !flush_req;
        if (flush_req) begin
            exp_q.delete();
        end else begin
            if (popped) begin
                void'(exp_q.pop_front());
            end
            if (pushed) begin
                exp_q.push_back(model_entry(fi));
            end
        end
        @(posedge clk);
    endtask

    task automatic push_one(input fetch_instr_t fi, input logic ready);
        logic pushed;
        logic popped;
        int   n;
        pushed = 1'b0;
        n      = 0;
        while (!pushed && n < TIMEOUT) begin
            run_cycle(1'b1, fi, ready, 1'b0, pushed, popped);
            n++;
        end
        if (!pushed) begin
            $display("Timeout: fetch side never accepted instruction at pc %0h", fi.pc);
            other_errors++;
        end
    endtask

    task automatic issue_one(output iq_entry_t got);
        logic pushed;
        logic popped;
        int   n;
        popped = 1'b0;
        n      = 0;
        got    = '0;
        while (!popped && n < TIMEOUT) begin
            run_cycle(1'b0, '0, 1'b1, 1'b0, pushed, popped);
            n++;
        end
        if (popped) begin
            got = seen_entry;
        end else begin
            $display("Timeout: no instruction was issued within %0d cycles", TIMEOUT);
            other_errors++;
        end
    endtask

    task automatic drain_queue();
        logic pushed;
        logic popped;
        int   n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            run_cycle(1'b0, '0, 1'b1, 1'b0, pushed, popped);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: queue did not drain, %0d entries left", exp_q.size());
            other_errors++;
        end
    endtask

    task automatic check_after_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            other_errors++;
        end
        @(negedge clk);
        #SETTLE;
        check_value("issue_valid_o", 68'(1'b0), 68'(issue_valid));
        check_value("fetch_ready_o", 68'(1'b1), 68'(fetch_ready));
    endtask

    // Long mixed traffic so both indices wrap several times
    task automatic run_random_traffic();
        logic valid;
        logic ready;
        logic pushed;
        logic popped;
        int   pushes;
        pushes = 0;
        for (int i = 0; i < 240; i++) begin
            valid = (next_bits(2) != 32'd0);
            ready = (next_bits(1) != 32'd0);
            run_cycle(valid, random_fetch(), ready, 1'b0, pushed, popped);
            if (pushed) begin
                pushes++;
            end
        end
        drain_queue();
        if (pushes < 3 * `IQ_DEPTH) begin
            $display("Random traffic pushed only %0d entries, too few to wrap", pushes);
            other_errors++;
        end
    endtask

    task automatic classify_case(input logic [6:0] opc, input logic fault,
                                 input iq_unit_t unit, input logic illegal);
        fetch_instr_t fi;
        iq_entry_t    got;
        logic [31:0]  upper;
        upper     = next_bits(25);
        fi.pc     = next_bits(32);
        fi.instr  = {upper[24:0], opc};
        fi.except = fault;
        push_one(fi, 1'b0);
        issue_one(got);
        check_value("issue_entry_o.unit", 68'(unit), 68'(got.unit));
        check_value("issue_entry_o.illegal", 68'(illegal), 68'(got.illegal));
    endtask

    task automatic check_predecode();
        drain_queue();
        classify_case(7'h33, 1'b0, `IQ_UNIT_ALU, 1'b0);
        classify_case(7'h13, 1'b0, `IQ_UNIT_ALU, 1'b0);
        classify_case(7'h37, 1'b0, `IQ_UNIT_ALU, 1'b0);
        classify_case(7'h17, 1'b0, `IQ_UNIT_ALU, 1'b0);
        classify_case(7'h63, 1'b0, `IQ_UNIT_BRANCH, 1'b0);
        classify_case(7'h6F, 1'b0, `IQ_UNIT_BRANCH, 1'b0);
        classify_case(7'h67, 1'b0, `IQ_UNIT_BRANCH, 1'b0);
        classify_case(7'h03, 1'b0, `IQ_UNIT_LSU, 1'b0);
        classify_case(7'h23, 1'b0, `IQ_UNIT_LSU, 1'b0);
        classify_case(7'h73, 1'b0, `IQ_UNIT_SYS, 1'b0);
        classify_case(7'h0F, 1'b0, `IQ_UNIT_SYS, 1'b0);
        // Custom-0 opcode is outside the table
        classify_case(7'h0B, 1'b0, `IQ_UNIT_SYS, 1'b1);
        // OP encoding with low bits 10
        classify_case(7'h32, 1'b0, `IQ_UNIT_SYS, 1'b1);
        classify_case(7'h33, 1'b1, `IQ_UNIT_SYS, 1'b1);
    endtask

    task automatic fill_and_stall();
        fetch_instr_t fi;
        fetch_instr_t first_fi;
        logic         pushed;
        logic         popped;
        first_fi = '0;
        drain_queue();
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            fi = random_fetch();
            if (i == 0) begin
                first_fi = fi;
            end
            push_one(fi, 1'b0);
        end
        // The head must hold while full and stalled
        for (int k = 0; k < 3; k++) begin
            run_cycle(1'b1, random_fetch(), 1'b0, 1'b0, pushed, popped);
            check_value("fetch_ready_o (full)", 68'(1'b0), 68'(seen_ready));
            check_value("issue_entry_o.pc (stalled)", 68'(first_fi.pc), 68'(seen_entry.pc));
        end
        // Push and pop together while full
        run_cycle(1'b1, random_fetch(), 1'b1, 1'b0, pushed, popped);
        check_value("fetch_ready_o (full, popping)", 68'(1'b1), 68'(seen_ready));
        check_value("issue_valid_o (full, popping)", 68'(1'b1), 68'(seen_valid));
        drain_queue();
    endtask

    task automatic flush_partial();
        fetch_instr_t fi;
        iq_entry_t    got;
        logic         pushed;
        logic         popped;
        drain_queue();
        for (int i = 0; i < 5; i++) begin
            push_one(random_fetch(), 1'b0);
        end
        run_cycle(1'b1, random_fetch(), 1'b0, 1'b1, pushed, popped);
        run_cycle(1'b0, '0, 1'b0, 1'b0, pushed, popped);
        check_value("issue_valid_o (after flush)", 68'(1'b0), 68'(seen_valid));
        fi = random_fetch();
        push_one(fi, 1'b0);
        issue_one(got);
        check_value("issue_entry_o.pc (after flush)", 68'(fi.pc), 68'(got.pc));
        check_value("issue_entry_o.instr (after flush)", 68'(fi.instr), 68'(got.instr));
    endtask

    initial begin
        flush          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_instr    = '0;
        issue_ready    = 1'b0;
        seen_ready     = 1'b0;
        seen_valid     = 1'b0;
        seen_entry     = '0;
        lfsr_q         = 32'd98598;
        value_errors   = 0;
        other_errors   = 0;
        assert_errors  = 0;

        check_after_reset();
        run_random_traffic();
        check_predecode();
        fill_and_stall();
        flush_partial();

        assert_errors = dut.u_chk.fail_count;
        $display("Done with %0d value mismatches, %0d other errors and %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/issue_queue_chk.sv
/* Issue queue checker
   Concurrent assertions on both handshakes of the bound top level */

`default_nettype none

`include "iq_defs.svh"

module issue_queue_chk
    import iq_pkg::*;
(
    input wire logic      clk_i,
    input wire logic      rst_n_i,
    input wire logic      flush_i,
    input wire logic      fetch_valid_i,
    input wire logic      fetch_ready_i,
    input wire logic      issue_ready_i,
    input wire logic      issue_valid_i,
    input wire iq_entry_t issue_entry_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OCC_W = `IQ_IDX_LEN + 1;
    localparam logic [OCC_W-1:0] OCC_FULL = OCC_W'(`IQ_DEPTH);

    // Occupancy rebuilt from the handshakes
    logic [OCC_W-1:0] occ_q;
    logic             push;
    logic             pop;

    // Count of failed assertions
    int unsigned      fail_count = 0;

    assign push = fetch_valid_i && fetch_ready_i;
    assign pop  = issue_valid_i && issue_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occ_q <= '0;
        end else if (flush_i) begin
            occ_q <= '0;
        end else if (push && !pop) begin
            occ_q <= occ_q + OCC_W'(1);
        end else if (pop && !push) begin
            occ_q <= occ_q - OCC_W'(1);
        end
    end

    // Nothing survives a flush
    a_flush_empties: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !issue_valid_i)
        else begin
            $error("issue_valid_o still high one cycle after a flush");
            fail_count++;
        end

    // A waiting head entry must not change under it
    a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i && !issue_ready_i && !flush_i |=> issue_valid_i && $stable(issue_entry_i))
        else begin
            $error("Head entry changed while waiting for issue_ready_i");
            fail_count++;
        end

    a_ready_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (occ_q != OCC_FULL) && !flush_i |-> fetch_ready_i)
        else begin
            $error("fetch_ready_o low although the queue is not full");
            fail_count++;
        end

    a_no_unknowns: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown({fetch_ready_i, issue_valid_i, issue_entry_i}))
        else begin
            $error("Unknown value on an issue queue output");
            fail_count++;
        end

endmodule

bind issue_queue issue_queue_chk u_chk (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_i (fetch_ready_o),
    .issue_ready_i (issue_ready_i),
    .issue_valid_i (issue_valid_o),
    .issue_entry_i (issue_entry_o)
);

`default_nettype wire

// File: tb/tb_clkgen.sv
/* Testbench clock and reset
   100 ns clock with an active-low reset held for the first two cycles */

`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: source/issue_queue.sv
/* Issue queue top level
   Predecoder in front of the circular buffer with its head and tail counters */

`default_nettype none

module issue_queue
    import iq_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         flush_i,

    // From fetch unit
    input  wire logic         fetch_valid_i,
    input  wire fetch_instr_t fetch_instr_i,
    output logic              fetch_ready_o,

    // To execution pipeline
    input  wire logic         issue_ready_i,
    output logic              issue_valid_o,
    output iq_entry_t         issue_entry_o
);

    iq_entry_t new_entry;
    iq_idx_t   head_idx;
    iq_idx_t   tail_idx;
    logic      head_cnt_en;
    logic      tail_cnt_en;
    logic      head_cnt_clr;
    logic      tail_cnt_clr;

    // Classify the incoming instruction
    iq_predecoder u_predecoder (
        .fetch_instr_i (fetch_instr_i),
        .new_entry_o   (new_entry)
    );

    issue_queue_fifo u_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .issue_ready_i  (issue_ready_i),
        .issue_valid_o  (issue_valid_o),
        .new_entry_i    (new_entry),
        .issued_entry_o (issue_entry_o),
        .head_idx_i     (head_idx),
        .tail_idx_i     (tail_idx),
        .head_cnt_en_o  (head_cnt_en),
        .tail_cnt_en_o  (tail_cnt_en),
        .head_cnt_clr_o (head_cnt_clr),
        .tail_cnt_clr_o (tail_cnt_clr)
    );

    // Read pointer
    iq_idx_counter u_head_cnt (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cnt_en_i  (head_cnt_en),
        .cnt_clr_i (head_cnt_clr),
        .cnt_o     (head_idx)
    );

    // Write pointer
    iq_idx_counter u_tail_cnt (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cnt_en_i  (tail_cnt_en),
        .cnt_clr_i (tail_cnt_clr),
        .cnt_o     (tail_idx)
    );

endmodule

`default_nettype wire

// File: source/issue_queue_fifo.sv
/* Issue queue buffer control
   Circular entry storage with ready/valid on both sides and head/tail counter control */

`default_nettype none

`include "iq_defs.svh"

module issue_queue_fifo
    import iq_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      flush_i,

    // Fetch side handshake
    input  wire logic      fetch_valid_i,
    output logic           fetch_ready_o,

    // Execution pipeline handshake
    input  wire logic      issue_ready_i,
    output logic           issue_valid_o,

    // Predecoded entry to write at the tail
    input  wire iq_entry_t new_entry_i,

    // Entry currently at the head
    output iq_entry_t      issued_entry_o,

    // External index counters
    input  wire iq_idx_t   head_idx_i,
    input  wire iq_idx_t   tail_idx_i,
    output logic           head_cnt_en_o,
    output logic           tail_cnt_en_o,
    output logic           head_cnt_clr_o,
    output logic           tail_cnt_clr_o
);

    // Entry storage, the valid field of each slot is the occupancy flag
    iq_entry_t [`IQ_DEPTH-1:0] iq_mem;

    logic [`IQ_DEPTH-1:0] valid_vec;
    logic                 fifo_full;
    logic                 head_valid;
    logic                 fifo_push;
    logic                 fifo_pop;

    // Gather the valid bits so full is a plain reduction
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            valid_vec[i] = iq_mem[i].valid;
        end
    end

    assign fifo_full  = &valid_vec;
    assign head_valid = iq_mem[head_idx_i].valid;

    // Head entry goes straight out, valid mirrors its occupancy
    assign issue_valid_o  = head_valid;
    assign issued_entry_o = iq_mem[head_idx_i];

    // Room if not full, or if the head leaves in this same cycle
    // No new entry is taken while a flush is dropping the contents
    assign fetch_ready_o = !flush_i && (!fifo_full || (head_valid && issue_ready_i));

    assign fifo_push = fetch_valid_i && fetch_ready_o;
    assign fifo_pop  = issue_valid_o && issue_ready_i;

    // Counter control
    // head follows pops, tail follows pushes, flush resets both
    assign head_cnt_en_o  = fifo_pop;
    assign tail_cnt_en_o  = fifo_push;
    assign head_cnt_clr_o = flush_i;
    assign tail_cnt_clr_o = flush_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                iq_mem[i] <= '0;
            end
        end else if (flush_i) begin
            // Dropping the valid bits empties the queue
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                iq_mem[i].valid <= 1'b0;
            end
        end else begin
            if (fifo_pop) begin
                iq_mem[head_idx_i].valid <= 1'b0;
            end
            // When full, tail equals head, so the push overrides the pop
            if (fifo_push) begin
                iq_mem[tail_idx_i] <= new_entry_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/iq_predecoder.sv
/* Issue queue predecoder
   Maps the major opcode of a fetched instruction to an execution unit */

`default_nettype none

`include "iq_defs.svh"

module iq_predecoder
    import iq_pkg::*;
(
    input  wire fetch_instr_t fetch_instr_i,
    output iq_entry_t         new_entry_o
);

    // RV32 major opcodes, low two bits are always 11
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    logic [6:0] opcode;
    iq_unit_t   unit;
    logic       known_opc;
    logic       bad_len;

    assign opcode = fetch_instr_i.instr[6:0];

    // Compressed or reserved encodings are not supported here
    assign bad_len = (opcode[1:0] != 2'b11);

    always_comb begin
        known_opc = 1'b1;
        unit      = `IQ_UNIT_SYS;
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                unit = `IQ_UNIT_ALU;
            end
            OPC_BRANCH, OPC_JAL, OPC_JALR: begin
                unit = `IQ_UNIT_BRANCH;
            end
            OPC_LOAD, OPC_STORE: begin
                unit = `IQ_UNIT_LSU;
            end
            OPC_SYSTEM, OPC_MISC_MEM: begin
                unit = `IQ_UNIT_SYS;
            end
            default: begin
                known_opc = 1'b0;
            end
        endcase
    end

    always_comb begin
        new_entry_o.valid   = 1'b1;
        new_entry_o.pc      = fetch_instr_i.pc;
        new_entry_o.instr   = fetch_instr_i.instr;
        new_entry_o.illegal = !known_opc || bad_len || fetch_instr_i.except;
        // Anything that must trap goes to the system unit
        if (new_entry_o.illegal) begin
            new_entry_o.unit = `IQ_UNIT_SYS;
        end else begin
            new_entry_o.unit = unit;
        end
    end

endmodule

`default_nettype wire

// File: source/iq_idx_counter.sv
/* Issue queue index counter
   Wraps modulo the queue depth, clear has priority over enable */

`default_nettype none

`include "iq_defs.svh"

module iq_idx_counter
    import iq_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic cnt_en_i,
    input  wire logic cnt_clr_i,
    output iq_idx_t   cnt_o
);

    iq_idx_t cnt_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_clr_i) begin
            // Flush brings the index back to the first slot
            cnt_q <= '0;
        end else if (cnt_en_i) begin
            // Wrap explicitly so any depth works, not just powers of two
            if (cnt_q == iq_idx_t'(`IQ_DEPTH - 1)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + iq_idx_t'(1);
            end
        end
    end

    assign cnt_o = cnt_q;

endmodule

`default_nettype wire

// File: source/iq_pkg.sv
/* Issue queue types
   Vector typedefs and the fetch and entry structs used across the design */

`default_nettype none

`include "iq_defs.svh"

package iq_pkg;

    // Queue index into the circular buffer
    typedef logic [`IQ_IDX_LEN-1:0] iq_idx_t;

    // Program counter and raw instruction word
    typedef logic [`XLEN-1:0] pc_t;
    typedef logic [`ILEN-1:0] instr_t;

    // Execution unit selector
    typedef logic [`IQ_UNIT_LEN-1:0] iq_unit_t;

    // Instruction as delivered by the fetch unit
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
        // Fetch fault, e.g. access error on the instruction fetch
        logic   except;
    } fetch_instr_t;

    // One slot of the issue queue
    typedef struct packed {
        logic     valid;
        iq_unit_t unit;
        // Entry must raise an exception when it reaches execution
        logic     illegal;
        pc_t      pc;
        instr_t   instr;
    } iq_entry_t;

endpackage

`default_nettype wire

// File: source/iq_defs.svh
/* Issue queue constants
   Queue sizing, datapath widths and execution unit codes */

`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// Queue sizing, index width must cover the depth
`define IQ_DEPTH    8
`define IQ_IDX_LEN  3

// Datapath widths
`define XLEN        32
`define ILEN        32

// Execution unit codes
`define IQ_UNIT_LEN     2
`define IQ_UNIT_ALU     2'd0
`define IQ_UNIT_BRANCH  2'd1
`define IQ_UNIT_LSU     2'd2
`define IQ_UNIT_SYS     2'd3

`endif
